/* hw/rv_pkg.sv */
// rv32i subset with word load and store only and without multiply, fence or system opcodes
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_sel_width = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;
    typedef logic [31:0] instr_t;

    // memory-mapped addresses that the core catches before they reach memory
    localparam word_t addr_out = 32'd1000;
    localparam word_t addr_halt = 32'd1004;

    localparam word_t instr_step = 32'd4;

    // base opcodes in instr[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // branch funct3 where 3'b010 and 3'b011 are reserved
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } br_funct_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_sel_t  rd;
        reg_sel_t  rs1;
        reg_sel_t  rs2;
        alu_op_e   alu_op;
        br_funct_e br_funct;
        logic      use_imm;
        // I, S, B or U immediate picked by opcode
        word_t     imm;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wr_data;
        logic  rd;
        logic  wr;
    } mem_req_t;

    typedef struct packed {
        word_t rd_data;
        logic  ack;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hw/rv_decode.sv */
// purely combinational; fields of unknown opcodes are decoded anyway and left to rv_ctrl to reject
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
    input  rv_pkg::instr_t   instr,
    output rv_pkg::decoded_t dec
);

    logic [2:0] funct3;
    logic alt;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;

    assign funct3 = instr[14:12];
    // funct7 bit 5 selects sub and sra
    assign alt = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec.opcode = rv_pkg::opcode_e'(instr[6:0]);
        dec.rd = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.br_funct = rv_pkg::br_funct_e'(funct3);

        case (funct3)
            3'b000: dec.alu_op = (dec.opcode == rv_pkg::op_reg && alt) ? rv_pkg::alu_sub
                                                                       : rv_pkg::alu_add;
            3'b001: dec.alu_op = rv_pkg::alu_sll;
            3'b010: dec.alu_op = rv_pkg::alu_slt;
            3'b011: dec.alu_op = rv_pkg::alu_sltu;
            3'b100: dec.alu_op = rv_pkg::alu_xor;
            // srai shares the funct7 encoding with sra
            3'b101: dec.alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110: dec.alu_op = rv_pkg::alu_or;
            default: dec.alu_op = rv_pkg::alu_and;
        endcase
        // lui, auipc and address generation all add
        if (dec.opcode != rv_pkg::op_reg && dec.opcode != rv_pkg::op_imm) begin
            dec.alu_op = rv_pkg::alu_add;
        end

        dec.use_imm = 1'b1;
        case (dec.opcode)
            rv_pkg::op_store: dec.imm = imm_s;
            rv_pkg::op_branch: dec.imm = imm_b;
            rv_pkg::op_lui, rv_pkg::op_auipc: dec.imm = imm_u;
            default: dec.imm = imm_i;
        endcase
        if (dec.opcode == rv_pkg::op_reg || dec.opcode == rv_pkg::op_branch) begin
            dec.use_imm = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
// 32 x 32 flop array with asynchronous reads; a write shows on reads after the clock edge
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_sel_t rs1,
    input  rv_pkg::reg_sel_t rs2,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wr_en,
    input  rv_pkg::reg_sel_t wr_sel,
    input  rv_pkg::word_t    wr_data
);

    localparam int num_regs = 2 ** rv_pkg::reg_sel_width;

    rv_pkg::word_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // x0 is hard-wired
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    wr_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wr_en));

endmodule

`default_nettype wire

/* hw/rv_alu.sv */
// combinational ALU and branch compare; shift amounts use only b[4:0]
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
    input  rv_pkg::word_t     a,
    input  rv_pkg::word_t     b,
    input  rv_pkg::alu_op_e   alu_op,
    input  rv_pkg::br_funct_e br_funct,
    output rv_pkg::word_t     result,
    output logic              take_branch
);

    logic [4:0] shamt;
    logic lt_signed;
    logic lt_unsigned;

    assign shamt = b[4:0];
    assign lt_signed = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add: begin
                result = a + b;
            end
            rv_pkg::alu_sub: begin
                result = a - b;
            end
            rv_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv_pkg::alu_slt: begin
                result = {31'b0, lt_signed};
            end
            rv_pkg::alu_sltu: begin
                result = {31'b0, lt_unsigned};
            end
            rv_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv_pkg::alu_srl: begin
                result = a >> shamt;
            end
            rv_pkg::alu_sra: begin
                // sign bit fills from the left
                result = $signed(a) >>> shamt;
            end
            rv_pkg::alu_or: begin
                result = a | b;
            end
            rv_pkg::alu_and: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_comb begin
        case (br_funct)
            rv_pkg::beq: take_branch = (a == b);
            rv_pkg::bne: take_branch = (a != b);
            rv_pkg::blt: take_branch = lt_signed;
            rv_pkg::bge: take_branch = !lt_signed;
            rv_pkg::bltu: take_branch = lt_unsigned;
            rv_pkg::bgeu: take_branch = !lt_unsigned;
            // reserved encodings fall through
            default: take_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_ctrl.sv */
// one instruction at a time; requests, out, outen and halt are registered and show one cycle late
`timescale 1ns/100ps
`default_nettype none

module rv_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::decoded_t  dec,
    output rv_pkg::instr_t    fetch_ack_instr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     alu_a,
    output rv_pkg::word_t     alu_b,
    input  rv_pkg::word_t     alu_result,
    input  logic              take_branch,
    output logic              rf_wr_en,
    output rv_pkg::reg_sel_t  rf_wr_sel,
    output rv_pkg::word_t     rf_wr_data,
    output rv_pkg::mem_req_t  mem_req,
    input  rv_pkg::mem_rsp_t  mem_rsp,
    output rv_pkg::word_t     out,
    output logic              outen,
    output logic              halt
);

    typedef enum logic [1:0] {
        fetch_wait,
        execute,
        data_wait,
        halted
    } state_e;

    state_e state, state_n;
    // a request is outstanding; low only right after reset
    logic pending, pending_n;
    rv_pkg::word_t pc, pc_n, next_pc;
    rv_pkg::instr_t ir;
    logic issue_rd, issue_wr, set_out, set_halt, writes_rd;
    rv_pkg::word_t req_addr, req_addr_n, req_wdata;
    logic req_rd, req_wr, req_any;

    assign fetch_ack_instr = ir;

    // auipc adds pc, lui adds zero, everything else starts from rs1
    assign alu_a = (dec.opcode == rv_pkg::op_auipc) ? pc
                 : (dec.opcode == rv_pkg::op_lui) ? '0 : rs1_data;
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    assign next_pc = (dec.opcode == rv_pkg::op_branch && take_branch) ? pc + dec.imm
                                                                      : pc + rv_pkg::instr_step;

    assign writes_rd = dec.opcode inside {rv_pkg::op_imm, rv_pkg::op_reg,
                                          rv_pkg::op_lui, rv_pkg::op_auipc};
    assign rf_wr_en = (state == execute && writes_rd)
                   || (state == data_wait && mem_rsp.ack && dec.opcode == rv_pkg::op_load);
    assign rf_wr_sel = dec.rd;
    assign rf_wr_data = (state == data_wait) ? mem_rsp.rd_data : alu_result;

    always_comb begin
        state_n = state;
        pending_n = pending;
        pc_n = pc;
        issue_rd = 1'b0;
        issue_wr = 1'b0;
        req_addr_n = pc;
        set_out = 1'b0;
        set_halt = 1'b0;
        case (state)
            fetch_wait: begin
                if (!pending) begin
                    issue_rd = 1'b1;
                    pending_n = 1'b1;
                end else if (mem_rsp.ack) begin
                    pending_n = 1'b0;
                    state_n = execute;
                end
            end
            execute: begin
                pc_n = next_pc;
                req_addr_n = next_pc;
                issue_rd = 1'b1;
                pending_n = 1'b1;
                state_n = fetch_wait;
                case (dec.opcode)
                    rv_pkg::op_imm, rv_pkg::op_reg, rv_pkg::op_lui,
                    rv_pkg::op_auipc, rv_pkg::op_branch: begin
                    end
                    rv_pkg::op_load: begin
                        req_addr_n = alu_result;
                        state_n = data_wait;
                    end
                    rv_pkg::op_store: begin
                        if (alu_result == rv_pkg::addr_out) begin
                            set_out = 1'b1;
                        end else if (alu_result == rv_pkg::addr_halt) begin
                            set_halt = 1'b1;
                        end else begin
                            issue_rd = 1'b0;
                            issue_wr = 1'b1;
                            req_addr_n = alu_result;
                            state_n = data_wait;
                        end
                    end
                    default: begin
                        set_halt = 1'b1;
                    end
                endcase
                if (set_halt) begin
                    issue_rd = 1'b0;
                    pending_n = 1'b0;
                    state_n = halted;
                end
            end
            data_wait: begin
                // pc already points past the load or store
                if (mem_rsp.ack) begin
                    issue_rd = 1'b1;
                    state_n = fetch_wait;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetch_wait;
            pending <= 1'b0;
            pc <= '0;
            req_rd <= 1'b0;
            req_wr <= 1'b0;
            out <= '0;
            outen <= 1'b0;
            halt <= 1'b0;
        end else begin
            state <= state_n;
            pending <= pending_n;
            pc <= pc_n;
            req_rd <= issue_rd;
            req_wr <= issue_wr;
            outen <= set_out;
            if (set_out) begin
                out <= rs2_data;
            end
            if (set_halt) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_wait && pending && mem_rsp.ack) begin
            ir <= mem_rsp.rd_data;
        end
        if (issue_rd || issue_wr) begin
            req_addr <= req_addr_n;
            req_wdata <= rs2_data;
        end
    end

    assign mem_req = '{addr: req_addr, wr_data: req_wdata, rd: req_rd, wr: req_wr};
    assign req_any = req_rd || req_wr;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(req_rd && req_wr));

    // at most one request in flight and the next waits for its ack
    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        req_any |=> !req_any until mem_rsp.ack);

    quiet_when_halted: assert property (@(posedge clk) disable iff (rst) halt |-> !req_any);

endmodule

`default_nettype wire

/* hw/rv_core.sv */
// core top; memory must answer every rd or wr pulse with exactly one ack pulse
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic             clk,
    input  logic             rst,
    output rv_pkg::mem_req_t mem_req,
    input  rv_pkg::mem_rsp_t mem_rsp,
    output rv_pkg::word_t    out,
    output logic             outen,
    output logic             halt
);

    rv_pkg::instr_t instr;
    rv_pkg::decoded_t dec;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic take_branch;
    logic rf_wr_en;
    rv_pkg::reg_sel_t rf_wr_sel;
    rv_pkg::word_t rf_wr_data;

    rv_ctrl i_ctrl (
        .clk             (clk),
        .rst             (rst),
        .dec             (dec),
        .fetch_ack_instr (instr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .alu_result      (alu_result),
        .take_branch     (take_branch),
        .rf_wr_en        (rf_wr_en),
        .rf_wr_sel       (rf_wr_sel),
        .rf_wr_data      (rf_wr_data),
        .mem_req         (mem_req),
        .mem_rsp         (mem_rsp),
        .out             (out),
        .outen           (outen),
        .halt            (halt)
    );

    rv_decode i_decode (
        .instr (instr),
        .dec   (dec)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (rf_wr_en),
        .wr_sel   (rf_wr_sel),
        .wr_data  (rf_wr_data)
    );

    rv_alu i_alu (
        .a           (alu_a),
        .b           (alu_b),
        .alu_op      (dec.alu_op),
        .br_funct    (dec.br_funct),
        .result      (alu_result),
        .take_branch (take_branch)
    );

endmodule

`default_nettype wire

/* tb/tb_mem.sv */
// 2 KB word memory that ignores byte address bits above 10; each request acks after 1 to 3 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_mem (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::mem_req_t mem_req,
    output rv_pkg::mem_rsp_t mem_rsp
);

    localparam int num_words = 512;

    rv_pkg::word_t words [num_words];
    integer seed = 32'hf5dd_4d4e;
    logic busy;
    logic is_read;
    rv_pkg::word_t addr;
    int wait_cnt;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_rsp <= '0;
            busy <= 1'b0;
            is_read <= 1'b0;
            addr <= '0;
            wait_cnt <= 0;
        end else begin
            mem_rsp.ack <= 1'b0;
            if (busy) begin
                if (wait_cnt == 0) begin
                    mem_rsp.ack <= 1'b1;
                    if (is_read) begin
                        mem_rsp.rd_data <= words[addr[10:2]];
                    end
                    busy <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req.rd || mem_req.wr) begin
                busy <= 1'b1;
                is_read <= mem_req.rd;
                addr <= mem_req.addr;
                // zero here means the ack follows one cycle after the request
                wait_cnt <= $unsigned($random(seed)) % 3;
                if (mem_req.wr) begin
                    words[mem_req.addr[10:2]] = mem_req.wr_data;
                end
            end
        end
    end

    // every word gets a value tied to its full byte address
    task automatic fill();
        for (int i = 0; i < num_words; i++) begin
            words[i] = rv_pkg::word_t'(i * 4) ^ 32'h5a5a_0000;
        end
    endtask

    task automatic write_word(input rv_pkg::word_t a, input rv_pkg::word_t d);
        words[a[10:2]] = d;
    endtask

    function automatic rv_pkg::word_t read_word(input rv_pkg::word_t a);
        return words[a[10:2]];
    endfunction

endmodule

`default_nettype wire

/* tb/tb_core.sv */
// directed tests for rv_core; every program starts at address 0 and must end in a halt
`timescale 1ns/100ps
`default_nettype none

module tb_core;

    logic clk;
    logic rst;
    rv_pkg::mem_req_t mem_req;
    rv_pkg::mem_rsp_t mem_rsp;
    rv_pkg::word_t out;
    logic outen;
    logic halt;

    rv_pkg::instr_t prog[$];
    rv_pkg::word_t expect_q[$];
    rv_pkg::word_t out_q[$];
    string test_name;
    int test_errors;
    int tests_clean = 0;
    int tests_failed = 0;
    int cycle_limit = 200;
    int cycles = 0;

    rv_core i_dut (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .out     (out),
        .outen   (outen),
        .halt    (halt)
    );

    tb_mem i_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // out values in the order the core emits them
    always @(posedge clk) begin
        if (!rst && outen) begin
            out_q.push_back(out);
        end
    end

    function automatic rv_pkg::instr_t i_type(input rv_pkg::opcode_e op, input logic [2:0] f3,
        input rv_pkg::reg_sel_t rd, input rv_pkg::reg_sel_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
        input rv_pkg::reg_sel_t rd, input rv_pkg::reg_sel_t rs1, input rv_pkg::reg_sel_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic rv_pkg::instr_t s_type(input logic [11:0] imm,
        input rv_pkg::reg_sel_t rs2, input rv_pkg::reg_sel_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::instr_t b_type(input rv_pkg::br_funct_e f3,
        input rv_pkg::reg_sel_t rs1, input rv_pkg::reg_sel_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::instr_t u_type(input rv_pkg::opcode_e op,
        input rv_pkg::reg_sel_t rd, input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::instr_t store_out(input rv_pkg::reg_sel_t rs);
        return s_type(12'd1000, rs, 5'd0);
    endfunction

    function automatic rv_pkg::instr_t store_halt();
        return s_type(12'd1004, 5'd0, 5'd0);
    endfunction

    task automatic check_word(input string what, input rv_pkg::word_t expected,
        input rv_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name = name;
        test_errors = 0;
        prog.delete();
        expect_q.delete();
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
            tests_clean++;
        end else begin
            $display("%s: %0d mismatches", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // load while the core is held in reset, then release it and wait for halt
    task automatic run_program();
        @(posedge clk);
        rst <= 1'b1;
        i_mem.fill();
        foreach (prog[i]) begin
            i_mem.write_word(rv_pkg::word_t'(i * 4), prog[i]);
        end
        cycle_limit += prog.size() * 10;
        out_q.delete();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (halt !== 1'b1) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic compare_outputs();
        int n;
        check_word("output count", rv_pkg::word_t'(expect_q.size()),
                   rv_pkg::word_t'(out_q.size()));
        n = (expect_q.size() < out_q.size()) ? expect_q.size() : out_q.size();
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("output %0d", i), expect_q[i], out_q[i]);
        end
    endtask

    task automatic watch_halted();
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check_flag("halt held", 1'b1, halt);
            check_flag("request after halt", 1'b0, mem_req.rd || mem_req.wr);
        end
    endtask

    task automatic alu_immediates();
        rv_pkg::word_t auipc_pc;
        open_test("alu_immediates");
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 0, -5));
        prog.push_back(store_out(1));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 2, 1, -100));
        prog.push_back(store_out(2));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b100, 3, 1, 12'h0f0));
        prog.push_back(store_out(3));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 5, 0, 12'h123));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b110, 4, 5, 12'h450));
        prog.push_back(store_out(4));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b111, 6, 5, -16));
        prog.push_back(store_out(6));
        // srai by 2
        prog.push_back(i_type(rv_pkg::op_imm, 3'b101, 9, 1, 12'h402));
        prog.push_back(store_out(9));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b010, 10, 1, 1));
        prog.push_back(store_out(10));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b011, 11, 1, 1));
        prog.push_back(store_out(11));
        prog.push_back(u_type(rv_pkg::op_lui, 7, 20'habcde));
        prog.push_back(store_out(7));
        auipc_pc = rv_pkg::word_t'(prog.size() * 4);
        prog.push_back(u_type(rv_pkg::op_auipc, 8, 20'h12345));
        prog.push_back(store_out(8));
        prog.push_back(store_halt());
        expect_q = '{32'hffff_fffb, 32'hffff_ff97, 32'hffff_ff0b, 32'h0000_0573,
                     32'h0000_0120, 32'hffff_fffe, 32'h1, 32'h0, 32'habcd_e000};
        expect_q.push_back(32'h1234_5000 + auipc_pc);
        run_program();
        compare_outputs();
        close_test();
    endtask

    task automatic register_ops();
        open_test("register_ops");
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 0, -200));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 2, 0, 9));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 4, 0, 5));
        prog.push_back(r_type(7'h00, 3'b000, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h20, 3'b000, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b111, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b110, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b100, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b001, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b101, 3, 1, 2));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h20, 3'b101, 3, 1, 2));
        prog.push_back(store_out(3));
        // -200 against 5 orders differently signed and unsigned
        prog.push_back(r_type(7'h00, 3'b010, 3, 1, 4));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b011, 3, 1, 4));
        prog.push_back(store_out(3));
        prog.push_back(r_type(7'h00, 3'b000, 0, 1, 2));
        prog.push_back(store_out(0));
        prog.push_back(store_halt());
        expect_q = '{32'hffff_ff41, 32'hffff_ff2f, 32'h0000_0008, 32'hffff_ff39,
                     32'hffff_ff31, 32'hfffe_7000, 32'h007f_ffff, 32'hffff_ffff,
                     32'h1, 32'h0, 32'h0};
        run_program();
        compare_outputs();
        close_test();
    endtask

    task automatic branches();
        open_test("branches");
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 0, 3));
        prog.push_back(store_out(1));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 1, -1));
        prog.push_back(b_type(rv_pkg::bne, 1, 0, -8));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 2, 0, -1));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 3, 0, 1));
        for (int r = 4; r < 8; r++) begin
            prog.push_back(i_type(rv_pkg::op_imm, 3'b000, r, 0, r + 7));
        end
        // -1 is below 1 signed but above it unsigned
        prog.push_back(b_type(rv_pkg::blt, 2, 3, 8));
        prog.push_back(store_out(4));
        prog.push_back(b_type(rv_pkg::bge, 2, 3, 8));
        prog.push_back(store_out(5));
        prog.push_back(b_type(rv_pkg::bltu, 2, 3, 8));
        prog.push_back(store_out(6));
        prog.push_back(b_type(rv_pkg::bgeu, 2, 3, 8));
        prog.push_back(store_out(7));
        prog.push_back(store_halt());
        expect_q = '{32'd3, 32'd2, 32'd1, 32'd12, 32'd13};
        run_program();
        compare_outputs();
        close_test();
    endtask

    task automatic load_store();
        open_test("load_store");
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 0, 12'h200));
        prog.push_back(u_type(rv_pkg::op_lui, 2, 20'h12345));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 2, 2, 12'h678));
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 3, 0, -7));
        prog.push_back(s_type(12'd0, 2, 1));
        prog.push_back(s_type(12'd4, 3, 1));
        prog.push_back(i_type(rv_pkg::op_load, 3'b010, 4, 1, 4));
        prog.push_back(store_out(4));
        prog.push_back(i_type(rv_pkg::op_load, 3'b010, 5, 1, 0));
        prog.push_back(store_out(5));
        prog.push_back(store_halt());
        expect_q = '{32'hffff_fff9, 32'h1234_5678};
        run_program();
        compare_outputs();
        check_word("memory at 0x200", 32'h1234_5678, i_mem.read_word(32'h200));
        check_word("memory at 0x204", 32'hffff_fff9, i_mem.read_word(32'h204));
        close_test();
    endtask

    task automatic halting();
        open_test("halting");
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 0, 42));
        prog.push_back(store_out(1));
        prog.push_back(store_halt());
        prog.push_back(store_out(1));
        expect_q = '{32'd42};
        run_program();
        watch_halted();
        compare_outputs();
        prog.delete();
        prog.push_back(i_type(rv_pkg::op_imm, 3'b000, 1, 0, 7));
        prog.push_back(store_out(1));
        // opcode 7'b1111111 is not part of the core
        prog.push_back(32'h0000_007f);
        prog.push_back(store_out(1));
        expect_q = '{32'd7};
        run_program();
        watch_halted();
        compare_outputs();
        close_test();
    endtask

    initial begin
        rst = 1'b1;
        alu_immediates();
        register_ops();
        branches();
        load_store();
        halting();
        $display("%0d tests clean, %0d tests with errors", tests_clean, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // limit grows with each loaded program
    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run hung: the core did not halt within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_ctrl.sv
hw/rv_core.sv
tb/tb_mem.sv
tb/tb_core.sv
